//--- logic/mm2s_csum_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, beat layout and insert states
// shared by the mm2s checksum offload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mm2s_csum_pkg;

   // bytes per beat on the dma write side
   localparam int BEAT_BYTES = 8;

   // packed beat layout {last, keep, data}
   localparam int DATA_W   = 8 * BEAT_BYTES;
   localparam int KEEP_LSB = DATA_W;
   localparam int LAST_BIT = KEEP_LSB + BEAT_BYTES;

   typedef logic [DATA_W-1:0]     beat_data_t;
   typedef logic [BEAT_BYTES-1:0] beat_keep_t;
   typedef logic [LAST_BIT:0]     fifo_word_t;

   // ones-complement sum, also the seed
   typedef logic [15:0] csum_t;

   // byte position inside a frame
   typedef logic [15:0] byte_off_t;

   // 0..8 valid bytes in a beat
   typedef logic [3:0] lane_cnt_t;

   // read-out fsm of csum_insert
   typedef enum logic [0:0] {
      INS_IDLE,
      INS_SEND
   } ins_state_e;

endpackage

`default_nettype wire

//--- logic/keep_to_cnt.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte count of a contiguous keep field
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module keep_to_cnt (
   input  wire mm2s_csum_pkg::beat_keep_t keep,
   output mm2s_csum_pkg::lane_cnt_t       cnt
);

   always_comb
   begin
      cnt = '0;
      // population count over the lanes
      for (int i = 0; i < mm2s_csum_pkg::BEAT_BYTES; i++)
      begin
         cnt = cnt + {3'b000, keep[i]};
      end
   end

   // keep must look like 0..01..1, lane 0 first
   // adding one then clears every set bit
   always_comb
   begin
      assert final ((keep & (keep + 1'b1)) == '0)
         else $error("keep_to_cnt: keep %h not contiguous from lane 0", keep);
   end

endmodule

`default_nettype wire

//--- logic/cnt_to_keep.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte count to low-lane mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cnt_to_keep (
   input  wire mm2s_csum_pkg::lane_cnt_t cnt,
   output mm2s_csum_pkg::beat_keep_t     keep
);

   // lane i is set when it falls below cnt
   // cnt of 8 and up gives all lanes
   always_comb
   begin
      keep = '0;
      for (int i = 0; i < mm2s_csum_pkg::BEAT_BYTES; i++)
      begin
         keep[i] = (i < cnt);
      end
   end

endmodule

`default_nettype wire

//--- logic/ofm_csum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// running ones-complement sum of a frame
// result and insert fields on the last beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ofm_csum (
   input  wire                              mm2s_clk,
   input  wire                              mm2s_resetn,
   input  wire                              data_fifo_wren,
   input  wire mm2s_csum_pkg::fifo_word_t   data_fifo_wdata,
   input  wire mm2s_csum_pkg::byte_off_t    tx_cs_begin,
   input  wire mm2s_csum_pkg::csum_t        tx_cs_init,
   input  wire mm2s_csum_pkg::byte_off_t    tx_cs_insert,
   input  wire                              tx_cs_en,
   output mm2s_csum_pkg::csum_t             tx_sum,
   output mm2s_csum_pkg::byte_off_t         frame_insert,
   output logic                             frame_en,
   output logic                             sum_valid
);

   mm2s_csum_pkg::beat_data_t data;
   mm2s_csum_pkg::beat_keep_t keep;
   mm2s_csum_pkg::beat_keep_t wr_keep;
   mm2s_csum_pkg::beat_keep_t skip_keep;
   mm2s_csum_pkg::beat_keep_t sum_mask;
   mm2s_csum_pkg::beat_data_t mdata;
   mm2s_csum_pkg::lane_cnt_t  beat_cnt;
   mm2s_csum_pkg::lane_cnt_t  skip_cnt;
   mm2s_csum_pkg::byte_off_t  bcnt;
   mm2s_csum_pkg::byte_off_t  beat_off;
   mm2s_csum_pkg::byte_off_t  skip_diff;
   mm2s_csum_pkg::csum_t      sum_q;
   mm2s_csum_pkg::csum_t      beat_sum;
   mm2s_csum_pkg::csum_t      sum_next;
   logic [16:0]               beat_end;
   logic                      last;
   logic                      sof;
   logic                      begin_hit_reg;
   logic                      begin_done;
   logic                      begin_in_beat;

   // 16-bit add with end-around carry
   function automatic mm2s_csum_pkg::csum_t add1c(input mm2s_csum_pkg::csum_t a,
                                                   input mm2s_csum_pkg::csum_t b);
      logic [16:0] s;
      s = {1'b0, a} + {1'b0, b};
      return s[15:0] + {15'b0, s[16]};
   endfunction

   assign data = data_fifo_wdata[mm2s_csum_pkg::DATA_W-1:0];
   assign keep = data_fifo_wdata[mm2s_csum_pkg::KEEP_LSB +: mm2s_csum_pkg::BEAT_BYTES];
   assign last = data_fifo_wdata[mm2s_csum_pkg::LAST_BIT];

   // idle bus carries no bytes
   assign wr_keep = data_fifo_wren ? keep : '0;

   keep_to_cnt beat_cnt_i (
      .keep (wr_keep),
      .cnt  (beat_cnt)
   );

   // offset of lane 0, first beat sits at 0
   assign beat_off = sof ? '0 : bcnt;
   assign beat_end = {1'b0, beat_off} + 17'(mm2s_csum_pkg::BEAT_BYTES);

   // begin already behind us, or inside this beat
   assign begin_done    = ~sof & begin_hit_reg;
   assign begin_in_beat = ({1'b0, tx_cs_begin} < beat_end);
   assign skip_diff     = tx_cs_begin - beat_off;
   assign skip_cnt      = skip_diff[3:0];

   // lanes ahead of the begin offset
   cnt_to_keep begin_mask_i (
      .cnt  (skip_cnt),
      .keep (skip_keep)
   );

   always_comb
   begin
      if (begin_done)
         sum_mask = keep;
      else if (begin_in_beat)
         sum_mask = keep & ~skip_keep;
      else
         sum_mask = '0;
   end

   // even lane is the high byte of each word
   always_comb
   begin
      for (int i = 0; i < mm2s_csum_pkg::BEAT_BYTES; i++)
      begin
         mdata[8*i +: 8] = sum_mask[i] ? data[8*i +: 8] : 8'h00;
      end
   end

   always_comb
   begin
      beat_sum = add1c(add1c({mdata[7:0],   mdata[15:8]},  {mdata[23:16], mdata[31:24]}),
                       add1c({mdata[39:32], mdata[47:40]}, {mdata[55:48], mdata[63:56]}));
      // seed enters on the first beat
      sum_next = add1c(sof ? tx_cs_init : sum_q, beat_sum);
   end

   // frame position, set again by every last beat
   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         sof       <= 1'b1;
         tx_sum    <= '0;
         frame_en  <= 1'b0;
         sum_valid <= 1'b0;
      end
      else
      begin
         sum_valid <= data_fifo_wren & last;
         if (data_fifo_wren)
         begin
            sof <= last;
            if (last)
            begin
               tx_sum   <= sum_next;
               frame_en <= tx_cs_en;
            end
         end
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (data_fifo_wren)
      begin
         sum_q         <= sum_next;
         bcnt          <= beat_off + {12'b0, beat_cnt};
         begin_hit_reg <= begin_done | begin_in_beat;
         if (last)
            frame_insert <= tx_cs_insert;
      end
   end

   // insert must land on a word boundary
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    data_fifo_wren && tx_cs_en |-> !tx_cs_insert[0])
      else $error("ofm_csum: odd insert offset %h", tx_cs_insert);

endmodule

`default_nettype wire

//--- logic/frame_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store-and-forward fifo of whole beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_buffer #(
   parameter int BUF_DEPTH = 64
) (
   input  wire                            mm2s_clk,
   input  wire                            mm2s_resetn,
   input  wire                            wr_en,
   input  wire mm2s_csum_pkg::fifo_word_t wr_data,
   input  wire                            rd_en,
   output mm2s_csum_pkg::fifo_word_t      rd_data,
   output logic                           empty,
   output logic                           full
);

   localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CW = $clog2(BUF_DEPTH + 1);

   mm2s_csum_pkg::fifo_word_t mem [BUF_DEPTH];
   logic [AW-1:0]             wr_ptr;
   logic [AW-1:0]             rd_ptr;
   logic [CW-1:0]             count;

   assign empty = (count == '0);
   assign full  = (count == CW'(BUF_DEPTH));

   // storage and registered read port
   always_ff @(posedge mm2s_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
      if (rd_en)
         rd_data <= mem[rd_ptr];
   end

   // pointers wrap at the depth
   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == AW'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == AW'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   // occupancy, unchanged on write plus read
   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
         count <= '0;
      else
      begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // writer honours full
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    wr_en |-> !full)
      else $error("frame_buffer: write while full");

   // reader only runs over complete frames
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    rd_en |-> !empty)
      else $error("frame_buffer: read while empty");

endmodule

`default_nettype wire

//--- logic/csum_insert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-frame results and read-out
// complemented sum patched in on the way out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module csum_insert #(
   parameter int META_DEPTH = 4
) (
   input  wire                            mm2s_clk,
   input  wire                            mm2s_resetn,
   input  wire                            sum_valid,
   input  wire mm2s_csum_pkg::csum_t      tx_sum,
   input  wire mm2s_csum_pkg::byte_off_t  frame_insert,
   input  wire                            frame_en,
   input  wire mm2s_csum_pkg::fifo_word_t rd_data,
   input  wire                            empty,
   output logic                           rd_en,
   output logic                           out_valid,
   output mm2s_csum_pkg::beat_data_t      out_data,
   output mm2s_csum_pkg::beat_keep_t      out_keep,
   output logic                           out_last
);

   localparam int MW = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
   localparam int MC = $clog2(META_DEPTH + 1);

   mm2s_csum_pkg::csum_t      meta_sum [META_DEPTH];
   mm2s_csum_pkg::byte_off_t  meta_ins [META_DEPTH];
   logic                      meta_en  [META_DEPTH];
   logic [MW-1:0]             meta_wptr;
   logic [MW-1:0]             meta_rptr;
   logic [MC-1:0]             meta_cnt;
   logic                      meta_empty;
   logic                      meta_pop;
   mm2s_csum_pkg::ins_state_e state;
   mm2s_csum_pkg::byte_off_t  beat_off;
   mm2s_csum_pkg::byte_off_t  ins_hi;
   mm2s_csum_pkg::byte_off_t  ins_lo;
   mm2s_csum_pkg::csum_t      ins_val;

   assign meta_empty = (meta_cnt == '0);
   assign meta_pop   = out_valid & out_last;

   // head of the queue drives the patch
   assign ins_hi  = meta_ins[meta_rptr];
   assign ins_lo  = ins_hi + 16'd1;
   assign ins_val = ~meta_sum[meta_rptr];

   always_ff @(posedge mm2s_clk)
   begin
      if (sum_valid)
      begin
         meta_sum[meta_wptr] <= tx_sum;
         meta_ins[meta_wptr] <= frame_insert;
         meta_en[meta_wptr]  <= frame_en;
      end
   end

   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         meta_wptr <= '0;
         meta_rptr <= '0;
         meta_cnt  <= '0;
      end
      else
      begin
         if (sum_valid)
            meta_wptr <= (meta_wptr == MW'(META_DEPTH - 1)) ? '0 : meta_wptr + 1'b1;
         if (meta_pop)
            meta_rptr <= (meta_rptr == MW'(META_DEPTH - 1)) ? '0 : meta_rptr + 1'b1;
         meta_cnt <= meta_cnt + {{(MC-1){1'b0}}, sum_valid} - {{(MC-1){1'b0}}, meta_pop};
      end
   end

   // no read once the last beat is back
   assign rd_en = (state == mm2s_csum_pkg::INS_SEND) & ~meta_pop;

   always_ff @(posedge mm2s_clk or negedge mm2s_resetn)
   begin
      if (!mm2s_resetn)
      begin
         state     <= mm2s_csum_pkg::INS_IDLE;
         out_valid <= 1'b0;
         beat_off  <= '0;
      end
      else
      begin
         out_valid <= rd_en;
         case (state)
            mm2s_csum_pkg::INS_IDLE:
               if (!meta_empty)
                  state <= mm2s_csum_pkg::INS_SEND;
            default:
               if (meta_pop)
                  state <= mm2s_csum_pkg::INS_IDLE;
         endcase
         // offset of lane 0 in the outgoing beat
         if (out_valid)
            beat_off <= out_last ? '0 : beat_off + 16'(mm2s_csum_pkg::BEAT_BYTES);
      end
   end

   assign out_keep = rd_data[mm2s_csum_pkg::KEEP_LSB +: mm2s_csum_pkg::BEAT_BYTES];
   assign out_last = rd_data[mm2s_csum_pkg::LAST_BIT];

   // high byte of the checksum at the even offset
   always_comb
   begin
      out_data = rd_data[mm2s_csum_pkg::DATA_W-1:0];
      for (int i = 0; i < mm2s_csum_pkg::BEAT_BYTES; i++)
      begin
         if (meta_en[meta_rptr] && (beat_off + 16'(i) == ins_hi))
            out_data[8*i +: 8] = ins_val[15:8];
         else if (meta_en[meta_rptr] && (beat_off + 16'(i) == ins_lo))
            out_data[8*i +: 8] = ins_val[7:0];
      end
   end

   // a result arrives only with room for it
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    sum_valid && !meta_pop |-> meta_cnt < MC'(META_DEPTH))
      else $error("csum_insert: result queue overflow");

   // a queued result means its frame still sits in the buffer
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    !meta_empty && !meta_pop |-> !empty)
      else $error("csum_insert: result queued with no frame in the buffer");

endmodule

`default_nettype wire

//--- logic/mm2s_csum_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mm2s tx checksum offload, dma write side in
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mm2s_csum_top #(
   parameter int BUF_DEPTH  = 64,
   parameter int META_DEPTH = 4
) (
   input  wire                            mm2s_clk,
   input  wire                            mm2s_resetn,
   input  wire                            data_fifo_wren,
   input  wire mm2s_csum_pkg::fifo_word_t data_fifo_wdata,
   input  wire mm2s_csum_pkg::byte_off_t  tx_cs_begin,
   input  wire mm2s_csum_pkg::csum_t      tx_cs_init,
   input  wire mm2s_csum_pkg::byte_off_t  tx_cs_insert,
   input  wire                            tx_cs_en,
   output wire                            buf_full,
   output wire mm2s_csum_pkg::csum_t      tx_sum,
   output wire                            out_valid,
   output wire mm2s_csum_pkg::beat_data_t out_data,
   output wire mm2s_csum_pkg::beat_keep_t out_keep,
   output wire                            out_last
);

   wire mm2s_csum_pkg::byte_off_t  frame_insert;
   wire                            frame_en;
   wire                            sum_valid;
   wire                            rd_en;
   wire mm2s_csum_pkg::fifo_word_t rd_data;
   wire                            empty;

   // sum runs alongside the buffer write
   ofm_csum csum_i (
      .mm2s_clk        (mm2s_clk),
      .mm2s_resetn     (mm2s_resetn),
      .data_fifo_wren  (data_fifo_wren),
      .data_fifo_wdata (data_fifo_wdata),
      .tx_cs_begin     (tx_cs_begin),
      .tx_cs_init      (tx_cs_init),
      .tx_cs_insert    (tx_cs_insert),
      .tx_cs_en        (tx_cs_en),
      .tx_sum          (tx_sum),
      .frame_insert    (frame_insert),
      .frame_en        (frame_en),
      .sum_valid       (sum_valid)
   );

   frame_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) buf_i (
      .mm2s_clk    (mm2s_clk),
      .mm2s_resetn (mm2s_resetn),
      .wr_en       (data_fifo_wren),
      .wr_data     (data_fifo_wdata),
      .rd_en       (rd_en),
      .rd_data     (rd_data),
      .empty       (empty),
      .full        (buf_full)
   );

   // read-out waits for the finished sum
   csum_insert #(
      .META_DEPTH (META_DEPTH)
   ) insert_i (
      .mm2s_clk     (mm2s_clk),
      .mm2s_resetn  (mm2s_resetn),
      .sum_valid    (sum_valid),
      .tx_sum       (tx_sum),
      .frame_insert (frame_insert),
      .frame_en     (frame_en),
      .rd_data      (rd_data),
      .empty        (empty),
      .rd_en        (rd_en),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .out_keep     (out_keep),
      .out_last     (out_last)
   );

endmodule

`default_nettype wire

//--- bench/mm2s_csum_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random frames through the checksum offload
// reference sums checked beat by beat on the output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mm2s_csum_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          NUM_FRAMES = 60;
   localparam int          BURST      = 20;
   localparam int          MAX_LEN    = 96;
   localparam int          META_DEPTH = 4;
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

   logic                            mm2s_clk;
   logic                            mm2s_resetn;
   logic                            data_fifo_wren;
   mm2s_csum_pkg::fifo_word_t       data_fifo_wdata;
   mm2s_csum_pkg::byte_off_t        tx_cs_begin;
   mm2s_csum_pkg::csum_t            tx_cs_init;
   mm2s_csum_pkg::byte_off_t        tx_cs_insert;
   logic                            tx_cs_en;
   wire                             buf_full;
   wire mm2s_csum_pkg::csum_t       tx_sum;
   wire                             out_valid;
   wire mm2s_csum_pkg::beat_data_t  out_data;
   wire mm2s_csum_pkg::beat_keep_t  out_keep;
   wire                             out_last;

   logic [31:0]                     lfsr = 32'h736473ee;
   logic [7:0]                      stim [$];
   mm2s_csum_pkg::fifo_word_t       exp_q [$];
   int                              f_len [NUM_FRAMES];
   int                              f_base [NUM_FRAMES];
   int                              f_begin [NUM_FRAMES];
   int                              f_ins [NUM_FRAMES];
   logic                            f_en [NUM_FRAMES];
   mm2s_csum_pkg::csum_t            f_seed [NUM_FRAMES];
   mm2s_csum_pkg::csum_t            f_sum [NUM_FRAMES];
   int                              total_beats = 0;
   int                              frames_done = 0;
   int                              frames_out = 0;
   logic                            first_beat = 1'b1;
   logic                            wrote_any = 1'b0;

   mm2s_csum_top #(
      .META_DEPTH (META_DEPTH)
   ) dut_i (
      .mm2s_clk        (mm2s_clk),
      .mm2s_resetn     (mm2s_resetn),
      .data_fifo_wren  (data_fifo_wren),
      .data_fifo_wdata (data_fifo_wdata),
      .tx_cs_begin     (tx_cs_begin),
      .tx_cs_init      (tx_cs_init),
      .tx_cs_insert    (tx_cs_insert),
      .tx_cs_en        (tx_cs_en),
      .buf_full        (buf_full),
      .tx_sum          (tx_sum),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_keep        (out_keep),
      .out_last        (out_last)
   );

   initial
   begin
      mm2s_clk = 1'b0;
      forever #50 mm2s_clk = ~mm2s_clk;
   end

   task automatic stop_failed();
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic run_error(input string text);
      $display("Error: %s", text);
      stop_failed();
   endtask

   task automatic value_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_failed();
   endtask

   // galois lfsr, one step per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return v;
   endfunction

   // seed plus bytes from begin to end, even offsets high
   function automatic mm2s_csum_pkg::csum_t frame_sum(input int f);
      logic [31:0] acc;
      acc = {16'h0000, f_seed[f]};
      for (int i = f_begin[f]; i < f_len[f]; i++)
      begin
         if (i % 2 == 0)
            acc = acc + {16'h0000, stim[f_base[f] + i], 8'h00};
         else
            acc = acc + {24'h000000, stim[f_base[f] + i]};
      end
      // fold carries back in
      while (acc[31:16] != 16'h0000)
         acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
      return acc[15:0];
   endfunction

   task automatic build_frames();
      int                        len;
      int                        base;
      int                        nb;
      int                        off;
      logic [7:0]                obuf [$];
      mm2s_csum_pkg::beat_data_t d;
      mm2s_csum_pkg::beat_keep_t k;
      base = 0;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         // one full beat, one short beat, a single byte, then random
         case (f)
            0:       len = 8;
            1:       len = 3;
            2:       len = 1;
            default: len = take_bits(7) % MAX_LEN + 1;
         endcase
         f_len[f]  = len;
         f_base[f] = base;
         for (int i = 0; i < len; i++)
            stim.push_back(take_bits(8));
         f_begin[f] = take_bits(16) % len;
         f_seed[f]  = take_bits(16);
         f_ins[f]   = 2 * (take_bits(16) % ((len + 1) / 2));
         f_en[f]    = (take_bits(2) != 0);
         f_sum[f]   = frame_sum(f);
         obuf.delete();
         for (int i = 0; i < len; i++)
            obuf.push_back(stim[base + i]);
         // complemented sum, high byte first
         if (f_en[f])
         begin
            obuf[f_ins[f]] = ~f_sum[f][15:8];
            if (f_ins[f] + 1 < len)
               obuf[f_ins[f] + 1] = ~f_sum[f][7:0];
         end
         nb = (len + 7) / 8;
         for (int b = 0; b < nb; b++)
         begin
            d = '0;
            k = '0;
            for (int lane = 0; lane < 8; lane++)
            begin
               off = b * 8 + lane;
               if (off < len)
               begin
                  d[8*lane +: 8] = obuf[off];
                  k[lane]        = 1'b1;
               end
            end
            exp_q.push_back({(b == nb - 1), k, d});
         end
         total_beats = total_beats + nb;
         base        = base + len;
      end
   endtask

   task automatic send_frame(input int f, input logic no_gaps);
      int                        nb;
      int                        gap;
      int                        off;
      mm2s_csum_pkg::fifo_word_t w;
      nb = (f_len[f] + 7) / 8;
      // keep finished results within the dut queue
      while (frames_done - frames_out >= META_DEPTH - 1)
      begin
         @(posedge mm2s_clk);
         #10;
      end
      tx_cs_begin  = f_begin[f];
      tx_cs_init   = f_seed[f];
      tx_cs_insert = f_ins[f];
      tx_cs_en     = f_en[f];
      for (int b = 0; b < nb; b++)
      begin
         gap = no_gaps ? 0 : take_bits(2);
         repeat (gap)
         begin
            @(posedge mm2s_clk);
            #10;
         end
         while (buf_full)
         begin
            @(posedge mm2s_clk);
            #10;
         end
         w = '0;
         for (int lane = 0; lane < 8; lane++)
         begin
            off = b * 8 + lane;
            if (off < f_len[f])
            begin
               w[8*lane +: 8]                        = stim[f_base[f] + off];
               w[mm2s_csum_pkg::KEEP_LSB + lane]     = 1'b1;
            end
         end
         w[mm2s_csum_pkg::LAST_BIT] = (b == nb - 1);
         data_fifo_wdata = w;
         data_fifo_wren  = 1'b1;
         wrote_any       = 1'b1;
         @(posedge mm2s_clk);
         #10;
         data_fifo_wren = 1'b0;
      end
      frames_done++;
   endtask

   // nothing leaves and nothing fills before the first write
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    !wrote_any |-> !out_valid && !buf_full)
      else run_error("out_valid or buf_full high before any frame was written");

   // only the last beat may be partial
   assert property (@(posedge mm2s_clk) disable iff (!mm2s_resetn)
                    out_valid && !out_last |-> out_keep == 8'hff)
      else run_error("partial keep on a beat that is not last");

   // outputs sampled mid-cycle, away from the clock edge
   always @(negedge mm2s_clk)
   begin : out_monitor
      mm2s_csum_pkg::fifo_word_t exp_w;
      mm2s_csum_pkg::beat_data_t mask;
      if (mm2s_resetn && out_valid)
      begin
         if (exp_q.size() == 0)
            run_error("out_valid with no beat left to expect");
         else
         begin
            exp_w = exp_q.pop_front();
            for (int lane = 0; lane < 8; lane++)
               mask[8*lane +: 8] = {8{exp_w[mm2s_csum_pkg::KEEP_LSB + lane]}};
            assert (out_keep == exp_w[mm2s_csum_pkg::KEEP_LSB +: 8])
               else value_mismatch("out_keep", out_keep, exp_w[mm2s_csum_pkg::KEEP_LSB +: 8]);
            assert (out_last == exp_w[mm2s_csum_pkg::LAST_BIT])
               else value_mismatch("out_last", out_last, exp_w[mm2s_csum_pkg::LAST_BIT]);
            assert ((out_data & mask) == (exp_w[63:0] & mask))
               else value_mismatch("out_data", out_data & mask, exp_w[63:0] & mask);
            // tx_sum still holds this frame's result
            if (first_beat && frames_done == frames_out + 1)
               assert (tx_sum == f_sum[frames_out])
                  else value_mismatch("tx_sum", tx_sum, f_sum[frames_out]);
            first_beat = out_last;
            if (out_last)
               frames_out++;
         end
      end
   end

   initial
   begin : watchdog
      wait (total_beats > 0);
      repeat (total_beats * 20 + 1000) @(posedge mm2s_clk);
      run_error("watchdog expired before all frames drained");
   end

   initial
   begin
      mm2s_resetn     = 1'b0;
      data_fifo_wren  = 1'b0;
      data_fifo_wdata = '0;
      tx_cs_begin     = '0;
      tx_cs_init      = '0;
      tx_cs_insert    = '0;
      tx_cs_en        = 1'b0;
      build_frames();
      repeat (4) @(posedge mm2s_clk);
      #10;
      mm2s_resetn = 1'b1;
      // spaced frames first, the tail back to back
      for (int f = 0; f < NUM_FRAMES; f++)
         send_frame(f, f >= NUM_FRAMES - BURST);
      wait (frames_out == NUM_FRAMES);
      repeat (5) @(posedge mm2s_clk);
      if (exp_q.size() == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
         run_error("expected beats left over after the last frame");
   end

endmodule

`default_nettype wire

//--- flist.f
logic/mm2s_csum_pkg.sv
logic/keep_to_cnt.sv
logic/cnt_to_keep.sv
logic/ofm_csum.sv
logic/frame_buffer.sv
logic/csum_insert.sv
logic/mm2s_csum_top.sv
bench/mm2s_csum_tb.sv

//--- Bender.yml
package:
  name: mm2s_csum

sources:
  - logic/mm2s_csum_pkg.sv
  - logic/keep_to_cnt.sv
  - logic/cnt_to_keep.sv
  - logic/ofm_csum.sv
  - logic/frame_buffer.sv
  - logic/csum_insert.sv
  - logic/mm2s_csum_top.sv
  - target: test
    files:
      - bench/mm2s_csum_tb.sv
